/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
    import riscv_pkg::*;
(
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_e     op,
    output logic [31:0] result,
    output logic        equal
);

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};   // signed compare
            ALU_PASS_B: result = b;
            default:    result = 32'd0;
        endcase
    end

    // beq / bne compare
    assign equal = (a == b);

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import riscv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fetch_t      fetch,
    input  wb_fwd_t     wb,
    output redirect_t   redirect,
    output ex_wb_t      ex_wb,
    output logic        dmem_we,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata
);

    fetch_t      fetch_q;     // execute input registers
    opcode_e     opcode;
    logic [31:0] inst;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [31:0] imm;
    logic        reg_we, b_imm, is_store, is_branch, is_jal;
    wb_sel_e     wb_sel;
    alu_op_e     alu_op;
    logic [4:0]  rs1, rs2;
    logic [31:0] rf_rd1, rf_rd2;
    logic [31:0] op_a, rs2_val, op_b;
    logic [31:0] alu_result;
    logic        alu_equal;

    always_ff @(posedge clk) begin
        fetch_q <= fetch;
        if (rst) fetch_q.valid <= 1'b0;
    end

    assign inst   = fetch_q.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // decode, anything unsupported falls to a no-op
    always_comb begin
        reg_we    = 1'b0;
        wb_sel    = WB_ALU;
        alu_op    = ALU_ADD;
        b_imm     = 1'b0;
        imm       = imm_i;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        case (opcode)
            OPC_OP: begin
                reg_we = 1'b1;
                case ({inst[31:25], inst[14:12]})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_111: alu_op = ALU_AND;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_010: alu_op = ALU_SLT;
                    default:         reg_we = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                reg_we = (inst[14:12] == 3'b000);   // addi only
                b_imm  = 1'b1;
            end
            OPC_LUI: begin
                reg_we = 1'b1;
                alu_op = ALU_PASS_B;
                b_imm  = 1'b1;
                imm    = imm_u;
            end
            OPC_LOAD: begin
                reg_we = (inst[14:12] == 3'b010);   // lw
                wb_sel = WB_MEM;
                b_imm  = 1'b1;
            end
            OPC_STORE: begin
                is_store = (inst[14:12] == 3'b010);   // sw
                b_imm    = 1'b1;
                imm      = imm_s;
            end
            OPC_BRANCH: begin
                is_branch = (inst[14:13] == 2'b00);   // beq, bne
                imm       = imm_b;
            end
            OPC_JAL: begin
                reg_we = 1'b1;
                wb_sel = WB_PC_PLUS4;
                is_jal = 1'b1;
                imm    = imm_j;
            end
            default: ;
        endcase
    end

    regfile u_regfile (
        .clk (clk),
        .ra1 (rs1),
        .ra2 (rs2),
        .rd1 (rf_rd1),
        .rd2 (rf_rd2),
        .wb  (wb)
    );

    // forward from writeback, covers load-use too
    assign op_a    = (wb.we && wb.rd != 5'd0 && wb.rd == rs1) ? wb.data : rf_rd1;
    assign rs2_val = (wb.we && wb.rd != 5'd0 && wb.rd == rs2) ? wb.data : rf_rd2;
    assign op_b    = b_imm ? imm : rs2_val;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op),
        .result (alu_result),
        .equal  (alu_equal)
    );

    // funct3[0] set means bne
    assign redirect.taken  = fetch_q.valid &
                             (is_jal | (is_branch & (alu_equal ^ inst[12])));
    assign redirect.target = fetch_q.pc + imm;

    assign dmem_we    = fetch_q.valid & is_store;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_val;

    // execute results, registered at the writeback boundary
    assign ex_wb.valid      = fetch_q.valid;
    assign ex_wb.reg_we     = fetch_q.valid & reg_we;
    assign ex_wb.rd         = inst[11:7];
    assign ex_wb.wb_sel     = wb_sel;
    assign ex_wb.alu_result = alu_result;
    assign ex_wb.pc_plus4   = fetch_q.pc + 32'd4;

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module fetch_stage
    import riscv_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    prog_we,
    input  logic [`IMEM_AWIDTH-1:0] prog_addr,
    input  logic [31:0]             prog_data,
    input  redirect_t               redirect,
    output fetch_t                  fetch
);

    logic [31:0] imem [`IMEM_DEPTH];

    logic [31:0] pc_q;      // last issued pc
    logic [31:0] pc_next;   // pc issued this cycle, addresses imem
    logic        valid_q;
    logic [31:0] inst_q;

    // first cycle after reset issues RESET_PC itself
    always_comb begin
        if (redirect.taken) begin
            pc_next = redirect.target;
        end else if (valid_q) begin
            pc_next = pc_q + 32'd4;
        end else begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= `RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= pc_next;
            valid_q <= 1'b1;
        end
    end

    // load port only while reset is held
    always_ff @(posedge clk) begin
        if (rst && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
        inst_q <= imem[pc_next[`IMEM_AWIDTH+1:2]];   // sync read
    end

    // instruction behind a taken redirect is flushed
    assign fetch.valid = valid_q & ~redirect.taken;
    assign fetch.pc    = pc_q;
    assign fetch.inst  = inst_q;

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
riscv_pkg.sv
alu.sv
regfile.sv
fetch_stage.sv
execute_stage.sv
mem_writeback.sv
riscv151_core.sv
riscv151_props.sv
tb_riscv151.sv

/* mem_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module mem_writeback
    import riscv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ex_wb_t      ex_wb,
    input  logic        dmem_we,
    input  logic [31:0] dmem_addr,
    input  logic [31:0] dmem_wdata,
    output wb_fwd_t     wb,
    output retire_t     retire
);

    logic [31:0] dmem [`DMEM_DEPTH];
    logic [31:0] dmem_q;
    ex_wb_t      ex_wb_q;

    // word access only, byte address bits 9:2
    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[`DMEM_AWIDTH+1:2]] <= dmem_wdata;
        end
        dmem_q <= dmem[dmem_addr[`DMEM_AWIDTH+1:2]];   // ready in writeback
    end

    always_ff @(posedge clk) begin
        ex_wb_q <= ex_wb;
        if (rst) begin
            ex_wb_q.valid  <= 1'b0;
            ex_wb_q.reg_we <= 1'b0;
        end
    end

    always_comb begin
        case (ex_wb_q.wb_sel)
            WB_MEM:      wb.data = dmem_q;
            WB_PC_PLUS4: wb.data = ex_wb_q.pc_plus4;   // jal link
            default:     wb.data = ex_wb_q.alu_result;
        endcase
    end

    assign wb.we = ex_wb_q.valid & ex_wb_q.reg_we;
    assign wb.rd = ex_wb_q.rd;

    // writes to x0 do not retire
    assign retire.valid = wb.we & (wb.rd != 5'd0);
    assign retire.rd    = wb.rd;
    assign retire.data  = wb.data;

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile
    import riscv_pkg::*;
(
    input  logic        clk,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  wb_fwd_t     wb
);

    logic [31:0] regs [32];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wb.we && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // async reads, x0 reads zero
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

`default_nettype wire

/* riscv151_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module riscv151_core
    import riscv_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    prog_we,     // honoured only in reset
    input  logic [`IMEM_AWIDTH-1:0] prog_addr,
    input  logic [31:0]             prog_data,
    output retire_t                 retire
);

    fetch_t      fetch;
    redirect_t   redirect;
    ex_wb_t      ex_wb;
    wb_fwd_t     wb;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;

    // pc, imem
    fetch_stage u_fetch (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .redirect  (redirect),
        .fetch     (fetch)
    );

    // decode, regfile, alu, branch resolution
    execute_stage u_execute (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .wb         (wb),
        .redirect   (redirect),
        .ex_wb      (ex_wb),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata)
    );

    // dmem and register write
    mem_writeback u_writeback (
        .clk        (clk),
        .rst        (rst),
        .ex_wb      (ex_wb),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .wb         (wb),
        .retire     (retire)
    );

endmodule

`default_nettype wire

/* riscv151_props.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv151_props
    import riscv_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input retire_t   retire,
    input redirect_t redirect,
    input ex_wb_t    ex_wb
);

    logic [2:0] settle;   // cycles since reset release, saturates

    always_ff @(posedge clk) begin
        if (rst) begin
            settle <= 3'd0;
        end else if (settle != 3'd7) begin
            settle <= settle + 3'd1;
        end
    end

    // pipe still filling
    quiet_after_reset: assert property (@(posedge clk)
        ($past(rst) || settle < 3'd3) |-> !retire.valid)
        else $error("retire.valid high during or just after reset");

    no_x0_retire: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> retire.rd != 5'd0)
        else $error("retire of register zero");

    // instruction behind a taken redirect enters execute invalid
    flushed_in_execute: assert property (@(posedge clk) disable iff (rst)
        redirect.taken |=> !ex_wb.valid)
        else $error("flushed instruction reached execute as valid");

endmodule

bind riscv151_core riscv151_props i_props (
    .clk      (clk),
    .rst      (rst),
    .retire   (retire),
    .redirect (redirect),
    .ex_wb    (ex_wb)
);

`default_nettype wire

/* riscv_consts.svh */
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// instruction memory, word addressed
`define IMEM_AWIDTH 8
`define IMEM_DEPTH  256

// data memory, word addressed by byte address bits 9:2
`define DMEM_AWIDTH 8
`define DMEM_DEPTH  256

`endif

/* riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B    // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS4
    } wb_sel_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        reg_we;
        wb_sel_e     wb_sel;
        logic [31:0] alu_result;
        logic [31:0] pc_plus4;
    } ex_wb_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } redirect_t;

    // register write, doubles as forwarding source
    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_fwd_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } retire_t;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_riscv151 -o tb_riscv151_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_riscv151_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF '*** PASSED ***'; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* tb_riscv151.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module tb_riscv151
    import riscv_pkg::*;
();

    typedef struct packed {
        logic [31:0] inst;
        retire_t     exp;   // exp.valid low means no retire
    } step_t;

    logic                    clk;
    logic                    rst;
    logic                    prog_we;
    logic [`IMEM_AWIDTH-1:0] prog_addr;
    logic [31:0]             prog_data;
    retire_t                 retire;

    step_t   steps[$];      // program in pc order
    retire_t expected[$];   // retires in program order

    riscv151_core i_riscv151_core (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // rv32i encoders
    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] imm_op(input opcode_e opc, input logic [2:0] f3,
                                           input logic [11:0] imm, input logic [4:0] rd,
                                           input logic [4:0] rs1);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] branch_insn(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] upper_imm(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] jump_link(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_step(input logic [31:0] inst, input logic ret, input logic [4:0] rd,
                            input logic [31:0] data);
        step_t s;
        s.inst      = inst;
        s.exp.valid = ret;
        s.exp.rd    = rd;
        s.exp.data  = data;
        steps.push_back(s);
        if (ret) expected.push_back(s.exp);
    endtask

    // expected values worked out by hand from the isa
    task automatic build_table();
        add_step(imm_op(OPC_OP_IMM, 3'b000, 12'd5, 5'd1, 5'd0), 1'b1, 5'd1, 32'h0000_0005);
        add_step(imm_op(OPC_OP_IMM, 3'b000, 12'hffd, 5'd2, 5'd0), 1'b1, 5'd2, 32'hffff_fffd);
        add_step(reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'h0000_0002);
        add_step(reg_op(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, 32'hffff_fffd);
        add_step(reg_op(7'h00, 3'b111, 5'd5, 5'd4, 5'd1), 1'b1, 5'd5, 32'h0000_0005);
        add_step(reg_op(7'h00, 3'b110, 5'd6, 5'd5, 5'd3), 1'b1, 5'd6, 32'h0000_0007);
        add_step(reg_op(7'h00, 3'b100, 5'd7, 5'd6, 5'd1), 1'b1, 5'd7, 32'h0000_0002);
        add_step(reg_op(7'h00, 3'b010, 5'd8, 5'd2, 5'd1), 1'b1, 5'd8, 32'h0000_0001);
        add_step(reg_op(7'h00, 3'b010, 5'd9, 5'd1, 5'd2), 1'b1, 5'd9, 32'h0000_0000);
        add_step(upper_imm(20'h12345, 5'd10), 1'b1, 5'd10, 32'h1234_5000);
        add_step(imm_op(OPC_OP_IMM, 3'b000, 12'h678, 5'd10, 5'd10), 1'b1, 5'd10, 32'h1234_5678);
        add_step(reg_op(7'h00, 3'b000, 5'd11, 5'd10, 5'd10), 1'b1, 5'd11, 32'h2468_acf0);
        add_step(reg_op(7'h20, 3'b000, 5'd12, 5'd11, 5'd10), 1'b1, 5'd12, 32'h1234_5678);
        add_step(reg_op(7'h00, 3'b100, 5'd13, 5'd12, 5'd11), 1'b1, 5'd13, 32'h365c_fa88);
        add_step(imm_op(OPC_OP_IMM, 3'b000, 12'h040, 5'd14, 5'd0), 1'b1, 5'd14, 32'h0000_0040);
        add_step(store_word(12'd8, 5'd14, 5'd13), 1'b0, 5'd0, 32'd0);
        add_step(imm_op(OPC_LOAD, 3'b010, 12'd8, 5'd15, 5'd14), 1'b1, 5'd15, 32'h365c_fa88);
        add_step(reg_op(7'h00, 3'b000, 5'd16, 5'd15, 5'd1), 1'b1, 5'd16, 32'h365c_fa8d);
        add_step(branch_insn(3'b000, 5'd1, 5'd1, 13'd8), 1'b0, 5'd0, 32'd0);   // beq taken
        add_step(imm_op(OPC_OP_IMM, 3'b000, 12'd1, 5'd17, 5'd0), 1'b0, 5'd0, 32'd0);
        add_step(branch_insn(3'b001, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0);   // bne taken
        add_step(imm_op(OPC_OP_IMM, 3'b000, 12'd2, 5'd17, 5'd0), 1'b0, 5'd0, 32'd0);
        add_step(branch_insn(3'b000, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0);
        add_step(branch_insn(3'b001, 5'd1, 5'd1, 13'd8), 1'b0, 5'd0, 32'd0);
        add_step(imm_op(OPC_OP_IMM, 3'b000, 12'd3, 5'd17, 5'd0), 1'b1, 5'd17, 32'h0000_0003);
        add_step(jump_link(21'd8, 5'd18), 1'b1, 5'd18, 32'h0000_0068);   // at pc 0x64
        add_step(imm_op(OPC_OP_IMM, 3'b000, 12'd4, 5'd19, 5'd0), 1'b0, 5'd0, 32'd0);
        add_step(imm_op(OPC_OP_IMM, 3'b000, 12'd7, 5'd0, 5'd0), 1'b0, 5'd0, 32'd0);
        add_step(reg_op(7'h00, 3'b000, 5'd20, 5'd0, 5'd18), 1'b1, 5'd20, 32'h0000_0068);
        add_step(jump_link(21'd0, 5'd0), 1'b0, 5'd0, 32'd0);   // spin here
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < steps.size(); i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = i[`IMEM_AWIDTH-1:0];
            prog_data = steps[i].inst;
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rd(input logic [4:0] exp, input logic [4:0] got);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t retire.rd expected x%0d observed x%0d",
                                $time, exp, got));
        end
    endtask

    task automatic check_retire(input retire_t exp, input retire_t got);
        if (got !== exp) begin
            abort_run($sformatf({"MISMATCH time=%0t retire (valid rd data) expected %0b x%0d %h",
                                 " observed %0b x%0d %h"}, $time, exp.valid, exp.rd, exp.data,
                                got.valid, got.rd, got.data));
        end
    endtask

    initial begin
        int limit;
        int cycles;
        int idx;
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = 32'd0;
        build_table();
        load_program();
        repeat (8) @(negedge clk);   // reset held past the load
        rst    = 1'b0;
        limit  = steps.size() * 4 + 40;
        cycles = 0;
        idx    = 0;
        while (idx < expected.size()) begin
            @(negedge clk);   // retire is stable mid cycle
            cycles++;
            if (cycles > limit) begin
                abort_run($sformatf({"timeout after %0d cycles, %0d of %0d retires missing,",
                                     " next x%0d"}, cycles, expected.size() - idx,
                                    expected.size(), expected[idx].rd));
            end else if (retire.valid) begin
                check_rd(expected[idx].rd, retire.rd);
                check_retire(expected[idx], retire);
                idx++;
            end
        end
        // core spins on jal x0, nothing more may retire
        repeat (10) begin
            @(negedge clk);
            if (retire.valid) begin
                abort_run($sformatf("unexpected retire of x%0d after the last expected one",
                                    retire.rd));
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
